/* gpu_consts.svh */
`ifndef GPU_CONSTS_SVH
`define GPU_CONSTS_SVH

// Cluster count and the bits to number one cluster
`define GPU_NUM_CLUSTERS    2
`define GPU_CLUSTER_BITS    1

// Memory word address and data
`define GPU_ADDR_WIDTH      16
`define GPU_DATA_WIDTH      32

// DCR write bus
`define GPU_DCR_ADDR_WIDTH  4
`define GPU_DCR_DATA_WIDTH  32

// Performance counters
`define GPU_PERF_BITS       32

`endif

/* gpu_pkg.sv */
package gpu_pkg;

    `include "gpu_consts.svh"

    // Request to memory; the tag names the issuing cluster
    typedef struct packed {
        logic                          rw;
        logic [`GPU_ADDR_WIDTH-1:0]    addr;
        logic [`GPU_DATA_WIDTH-1:0]    data;
        logic [`GPU_CLUSTER_BITS-1:0]  tag;
    } mem_req_t;

    // Read response, tag copied from the read
    typedef struct packed {
        logic [`GPU_DATA_WIDTH-1:0]    data;
        logic [`GPU_CLUSTER_BITS-1:0]  tag;
    } mem_rsp_t;

    typedef enum logic [`GPU_DCR_ADDR_WIDTH-1:0] {
        DCR_SRC_BASE   = 4'd0,
        DCR_DST_BASE   = 4'd1,
        DCR_WORD_COUNT = 4'd2,
        DCR_ADDEND     = 4'd3,
        DCR_START      = 4'd4
    } dcr_addr_e;

    // Cluster sequencer
    typedef enum logic [1:0] {
        CL_IDLE,
        CL_READ_WAIT,
        CL_WRITE
    } cluster_state_e;

    typedef logic [`GPU_PERF_BITS-1:0] perf_ctr_t;

endpackage

/* elastic_buf.sv */
`timescale 1ns/100ps

module elastic_buf #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready,
    output logic     empty
);

    payload_t   entries [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    assign in_ready  = count != 2'd2;
    assign out_valid = count != 2'd0;
    assign empty     = count == 2'd0;
    assign out_data  = entries[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    // Head item is never overwritten while it waits to leave
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

    // Producer keeps a refused item steady until it goes in
    assert property (@(posedge clk) disable iff (reset)
        in_valid && !in_ready |=> in_valid && $stable(in_data));

endmodule

/* mem_perf.sv */
`timescale 1ns/100ps

module mem_perf (
    input  logic               clk,
    input  logic               reset,
    input  logic               req_fire,
    input  logic               req_rw,
    input  logic               rsp_fire,
    output gpu_pkg::perf_ctr_t perf_reads,
    output gpu_pkg::perf_ctr_t perf_writes,
    output gpu_pkg::perf_ctr_t perf_latency
);
    import gpu_pkg::*;

    perf_ctr_t pending;
    logic      rd_fire;
    logic      wr_fire;

    assign rd_fire = req_fire && !req_rw;
    assign wr_fire = req_fire && req_rw;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending      <= '0;
            perf_reads   <= '0;
            perf_writes  <= '0;
            perf_latency <= '0;
        end else begin
            pending      <= pending + perf_ctr_t'(rd_fire) - perf_ctr_t'(rsp_fire);
            perf_reads   <= perf_reads + perf_ctr_t'(rd_fire);
            perf_writes  <= perf_writes + perf_ctr_t'(wr_fire);
            // Every outstanding read adds one cycle
            perf_latency <= perf_latency + pending;
        end
    end

endmodule

/* mem_arbiter.sv */
`timescale 1ns/100ps
`include "gpu_consts.svh"

module mem_arbiter (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic [`GPU_NUM_CLUSTERS-1:0]                   req_valid,
    input  logic [`GPU_NUM_CLUSTERS-1:0]                   req_rw,
    input  logic [`GPU_NUM_CLUSTERS-1:0][`GPU_ADDR_WIDTH-1:0] req_addr,
    input  logic [`GPU_NUM_CLUSTERS-1:0][`GPU_DATA_WIDTH-1:0] req_data,
    output logic [`GPU_NUM_CLUSTERS-1:0]                   req_ready,
    output logic [`GPU_NUM_CLUSTERS-1:0]                   rsp_valid,
    output logic [`GPU_NUM_CLUSTERS-1:0][`GPU_DATA_WIDTH-1:0] rsp_data,
    output logic                                           out_req_valid,
    output gpu_pkg::mem_req_t                              out_req,
    input  logic                                           out_req_ready,
    input  logic                                           in_rsp_valid,
    input  gpu_pkg::mem_rsp_t                              in_rsp,
    output logic                                           in_rsp_ready
);
    import gpu_pkg::*;

    localparam int N  = `GPU_NUM_CLUSTERS;
    localparam int CB = `GPU_CLUSTER_BITS;

    logic [CB-1:0] rr_ptr;
    logic [CB-1:0] pick;
    logic [CB-1:0] gnt;
    logic [CB-1:0] held_gnt;
    logic          found;
    logic          held;

    // First requester at or after the pointer
    always_comb begin
        int cand;
        pick  = rr_ptr;
        found = 1'b0;
        for (int k = N - 1; k >= 0; k--) begin
            cand = int'(rr_ptr) + k;
            if (cand >= N) begin
                cand = cand - N;
            end
            if (req_valid[cand]) begin
                pick  = CB'(cand);
                found = 1'b1;
            end
        end
    end

    // A stalled grant stays put so the offered request cannot change
    assign gnt           = held ? held_gnt : pick;
    assign out_req_valid = held || found;
    assign out_req.rw    = req_rw[gnt];
    assign out_req.addr  = req_addr[gnt];
    assign out_req.data  = req_data[gnt];
    assign out_req.tag   = gnt;

    always_comb begin
        req_ready      = '0;
        req_ready[gnt] = out_req_valid && out_req_ready;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr   <= '0;
            held     <= 1'b0;
            held_gnt <= '0;
        end else begin
            held     <= out_req_valid && !out_req_ready;
            held_gnt <= gnt;
            if (out_req_valid && out_req_ready) begin
                rr_ptr <= (gnt == CB'(N - 1)) ? '0 : gnt + 1'b1;
            end
        end
    end

    for (genvar i = 0; i < N; i++) begin : g_rsp
        assign rsp_valid[i] = in_rsp_valid && (in_rsp.tag == CB'(i));
        assign rsp_data[i]  = in_rsp.data;
    end

    assign in_rsp_ready = 1'b1;

endmodule

/* cluster_engine.sv */
`timescale 1ns/100ps
`include "gpu_consts.svh"

module cluster_engine #(
    parameter int CLUSTER_ID = 0
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  logic [`GPU_ADDR_WIDTH-1:0]      src_base,
    input  logic [`GPU_ADDR_WIDTH-1:0]      dst_base,
    input  logic [`GPU_DCR_DATA_WIDTH-1:0]  word_count,
    input  logic [`GPU_DATA_WIDTH-1:0]      addend,
    output logic                            busy,
    output logic                            req_valid,
    output logic                            req_rw,
    output logic [`GPU_ADDR_WIDTH-1:0]      req_addr,
    output logic [`GPU_DATA_WIDTH-1:0]      req_data,
    input  logic                            req_ready,
    input  logic                            rsp_valid,
    input  logic [`GPU_DATA_WIDTH-1:0]      rsp_data
);
    import gpu_pkg::*;

    cluster_state_e                  state;
    logic [`GPU_DCR_DATA_WIDTH-1:0]  idx;
    logic [`GPU_DCR_DATA_WIDTH-1:0]  next_idx;
    logic [`GPU_ADDR_WIDTH-1:0]      offset;
    logic [`GPU_DATA_WIDTH-1:0]      wr_data;
    logic                            rd_sent;
    logic                            has_work;

    // Stride over the indices owned by this cluster
    assign next_idx = idx + `GPU_DCR_DATA_WIDTH'(`GPU_NUM_CLUSTERS);
    assign has_work = idx < word_count;
    assign offset   = idx[`GPU_ADDR_WIDTH-1:0];

    assign busy      = state != CL_IDLE;
    assign req_rw    = state == CL_WRITE;
    assign req_valid = (state == CL_READ_WAIT && has_work && !rd_sent) || (state == CL_WRITE);
    assign req_addr  = req_rw ? dst_base + offset : src_base + offset;
    assign req_data  = wr_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= CL_IDLE;
            idx     <= '0;
            rd_sent <= 1'b0;
        end else begin
            case (state)
                CL_IDLE: begin
                    if (start) begin
                        state   <= CL_READ_WAIT;
                        idx     <= `GPU_DCR_DATA_WIDTH'(CLUSTER_ID);
                        rd_sent <= 1'b0;
                    end
                end
                CL_READ_WAIT: begin
                    // Empty slice still spends one busy cycle here
                    if (!has_work) begin
                        state <= CL_IDLE;
                    end else if (rsp_valid) begin
                        state   <= CL_WRITE;
                        rd_sent <= 1'b0;
                    end else if (req_valid && req_ready) begin
                        rd_sent <= 1'b1;
                    end
                end
                CL_WRITE: begin
                    if (req_ready) begin
                        idx   <= next_idx;
                        state <= (next_idx < word_count) ? CL_READ_WAIT : CL_IDLE;
                    end
                end
                default: state <= CL_IDLE;
            endcase
        end
    end

    // Sum captured with the response
    always_ff @(posedge clk) begin
        if (rsp_valid) begin
            wr_data <= rsp_data + addend;
        end
    end

    // Arbiter routes a response only to the cluster that owns the read
    assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> (state == CL_READ_WAIT && rd_sent));

endmodule

/* dcr_ctrl.sv */
`timescale 1ns/100ps
`include "gpu_consts.svh"

module dcr_ctrl (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            dcr_wr_valid,
    input  logic [`GPU_DCR_ADDR_WIDTH-1:0]  dcr_wr_addr,
    input  logic [`GPU_DCR_DATA_WIDTH-1:0]  dcr_wr_data,
    input  logic [`GPU_NUM_CLUSTERS-1:0]    cluster_busy,
    input  logic                            req_buf_empty,
    output logic                            start,
    output logic [`GPU_ADDR_WIDTH-1:0]      src_base,
    output logic [`GPU_ADDR_WIDTH-1:0]      dst_base,
    output logic [`GPU_DCR_DATA_WIDTH-1:0]  word_count,
    output logic [`GPU_DATA_WIDTH-1:0]      addend,
    output logic                            busy
);
    import gpu_pkg::*;

    dcr_addr_e wr_addr;
    logic      idle;

    assign wr_addr = dcr_addr_e'(dcr_wr_addr);

    // Nothing running, nothing launched and nothing left to drain
    assign idle = !busy && !start && !(|cluster_busy) && req_buf_empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            src_base   <= '0;
            dst_base   <= '0;
            word_count <= '0;
            addend     <= '0;
        end else if (dcr_wr_valid) begin
            case (wr_addr)
                DCR_SRC_BASE:   src_base   <= dcr_wr_data[`GPU_ADDR_WIDTH-1:0];
                DCR_DST_BASE:   dst_base   <= dcr_wr_data[`GPU_ADDR_WIDTH-1:0];
                DCR_WORD_COUNT: word_count <= dcr_wr_data;
                DCR_ADDEND:     addend     <= dcr_wr_data[`GPU_DATA_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            start <= 1'b0;
            busy  <= 1'b0;
        end else begin
            // START while busy is dropped
            start <= dcr_wr_valid && (wr_addr == DCR_START) && idle;
            busy  <= (|cluster_busy) || !req_buf_empty;
        end
    end

    // A launch finds every cluster idle
    assert property (@(posedge clk) disable iff (reset) start |-> !(|cluster_busy));

    // and wakes all of them
    assert property (@(posedge clk) disable iff (reset) start |=> (&cluster_busy));

endmodule

/* gpu_top.sv */
`timescale 1ns/100ps
`include "gpu_consts.svh"

module gpu_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            dcr_wr_valid,
    input  logic [`GPU_DCR_ADDR_WIDTH-1:0]  dcr_wr_addr,
    input  logic [`GPU_DCR_DATA_WIDTH-1:0]  dcr_wr_data,
    output logic                            mem_req_valid,
    output logic                            mem_req_rw,
    output logic [`GPU_ADDR_WIDTH-1:0]      mem_req_addr,
    output logic [`GPU_DATA_WIDTH-1:0]      mem_req_data,
    output logic [`GPU_CLUSTER_BITS-1:0]    mem_req_tag,
    input  logic                            mem_req_ready,
    input  logic                            mem_rsp_valid,
    input  logic [`GPU_DATA_WIDTH-1:0]      mem_rsp_data,
    input  logic [`GPU_CLUSTER_BITS-1:0]    mem_rsp_tag,
    output logic                            mem_rsp_ready,
    output logic                            busy,
    output gpu_pkg::perf_ctr_t              perf_reads,
    output gpu_pkg::perf_ctr_t              perf_writes,
    output gpu_pkg::perf_ctr_t              perf_latency
);
    import gpu_pkg::*;

    localparam int N = `GPU_NUM_CLUSTERS;

    logic                                  start;
    logic [`GPU_ADDR_WIDTH-1:0]            src_base;
    logic [`GPU_ADDR_WIDTH-1:0]            dst_base;
    logic [`GPU_DCR_DATA_WIDTH-1:0]        word_count;
    logic [`GPU_DATA_WIDTH-1:0]            addend;
    logic [N-1:0]                          cluster_busy;
    logic [N-1:0]                          cl_req_valid;
    logic [N-1:0]                          cl_req_rw;
    logic [N-1:0][`GPU_ADDR_WIDTH-1:0]     cl_req_addr;
    logic [N-1:0][`GPU_DATA_WIDTH-1:0]     cl_req_data;
    logic [N-1:0]                          cl_req_ready;
    logic [N-1:0]                          cl_rsp_valid;
    logic [N-1:0][`GPU_DATA_WIDTH-1:0]     cl_rsp_data;
    logic                                  arb_req_valid;
    logic                                  arb_req_ready;
    mem_req_t                              arb_req;
    logic                                  arb_rsp_valid;
    logic                                  arb_rsp_ready;
    mem_rsp_t                              arb_rsp;
    logic                                  req_buf_empty;
    mem_req_t                              mem_req;
    mem_rsp_t                              mem_rsp;
    logic                                  mem_req_fire;
    logic                                  mem_rsp_fire;

    assign mem_req_rw   = mem_req.rw;
    assign mem_req_addr = mem_req.addr;
    assign mem_req_data = mem_req.data;
    assign mem_req_tag  = mem_req.tag;
    assign mem_rsp.data = mem_rsp_data;
    assign mem_rsp.tag  = mem_rsp_tag;
    assign mem_req_fire = mem_req_valid && mem_req_ready;
    assign mem_rsp_fire = mem_rsp_valid && mem_rsp_ready;

    dcr_ctrl u_dcr_ctrl (
        .clk           (clk),
        .reset         (reset),
        .dcr_wr_valid  (dcr_wr_valid),
        .dcr_wr_addr   (dcr_wr_addr),
        .dcr_wr_data   (dcr_wr_data),
        .cluster_busy  (cluster_busy),
        .req_buf_empty (req_buf_empty),
        .start         (start),
        .src_base      (src_base),
        .dst_base      (dst_base),
        .word_count    (word_count),
        .addend        (addend),
        .busy          (busy)
    );

    for (genvar c = 0; c < N; c++) begin : g_clusters
        cluster_engine #(
            .CLUSTER_ID (c)
        ) u_cluster (
            .clk        (clk),
            .reset      (reset),
            .start      (start),
            .src_base   (src_base),
            .dst_base   (dst_base),
            .word_count (word_count),
            .addend     (addend),
            .busy       (cluster_busy[c]),
            .req_valid  (cl_req_valid[c]),
            .req_rw     (cl_req_rw[c]),
            .req_addr   (cl_req_addr[c]),
            .req_data   (cl_req_data[c]),
            .req_ready  (cl_req_ready[c]),
            .rsp_valid  (cl_rsp_valid[c]),
            .rsp_data   (cl_rsp_data[c])
        );
    end

    mem_arbiter u_arbiter (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (cl_req_valid),
        .req_rw        (cl_req_rw),
        .req_addr      (cl_req_addr),
        .req_data      (cl_req_data),
        .req_ready     (cl_req_ready),
        .rsp_valid     (cl_rsp_valid),
        .rsp_data      (cl_rsp_data),
        .out_req_valid (arb_req_valid),
        .out_req       (arb_req),
        .out_req_ready (arb_req_ready),
        .in_rsp_valid  (arb_rsp_valid),
        .in_rsp        (arb_rsp),
        .in_rsp_ready  (arb_rsp_ready)
    );

    elastic_buf #(
        .payload_t (mem_req_t)
    ) u_req_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (arb_req_valid),
        .in_data   (arb_req),
        .in_ready  (arb_req_ready),
        .out_valid (mem_req_valid),
        .out_data  (mem_req),
        .out_ready (mem_req_ready),
        .empty     (req_buf_empty)
    );

    elastic_buf #(
        .payload_t (mem_rsp_t)
    ) u_rsp_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (mem_rsp_valid),
        .in_data   (mem_rsp),
        .in_ready  (mem_rsp_ready),
        .out_valid (arb_rsp_valid),
        .out_data  (arb_rsp),
        .out_ready (arb_rsp_ready),
        .empty     ()
    );

    mem_perf u_mem_perf (
        .clk          (clk),
        .reset        (reset),
        .req_fire     (mem_req_fire),
        .req_rw       (mem_req_rw),
        .rsp_fire     (mem_rsp_fire),
        .perf_reads   (perf_reads),
        .perf_writes  (perf_writes),
        .perf_latency (perf_latency)
    );

endmodule

/* tb_gpu.sv */
`timescale 1ns/100ps
`include "gpu_consts.svh"

module tb_gpu;
    import gpu_pkg::*;

    localparam int N         = `GPU_NUM_CLUSTERS;
    localparam int CB        = `GPU_CLUSTER_BITS;
    localparam int COLS      = 6;
    localparam int MAX_JOBS  = 32;
    localparam int IDLE_WAIT = 5000;

    logic                            clk;
    logic                            reset;
    logic                            dcr_wr_valid;
    logic [`GPU_DCR_ADDR_WIDTH-1:0]  dcr_wr_addr;
    logic [`GPU_DCR_DATA_WIDTH-1:0]  dcr_wr_data;
    logic                            mem_req_valid;
    logic                            mem_req_rw;
    logic [`GPU_ADDR_WIDTH-1:0]      mem_req_addr;
    logic [`GPU_DATA_WIDTH-1:0]      mem_req_data;
    logic [CB-1:0]                   mem_req_tag;
    logic                            mem_req_ready;
    logic                            mem_rsp_valid;
    logic [`GPU_DATA_WIDTH-1:0]      mem_rsp_data;
    logic [CB-1:0]                   mem_rsp_tag;
    logic                            mem_rsp_ready;
    logic                            busy;
    perf_ctr_t                       perf_reads;
    perf_ctr_t                       perf_writes;
    perf_ctr_t                       perf_latency;

    logic [31:0] mem [0:65535];
    logic [31:0] expect_mem [0:65535];
    logic [31:0] tests [0:COLS*MAX_JOBS-1];
    int          req_count;
    // One read in flight per cluster, so one slot per tag
    logic        rsp_pending [N];
    logic [31:0] rsp_word [N];
    int          rsp_delay [N];

    gpu_top u_dut (
        .clk           (clk),
        .reset         (reset),
        .dcr_wr_valid  (dcr_wr_valid),
        .dcr_wr_addr   (dcr_wr_addr),
        .dcr_wr_data   (dcr_wr_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_rw    (mem_req_rw),
        .mem_req_addr  (mem_req_addr),
        .mem_req_data  (mem_req_data),
        .mem_req_tag   (mem_req_tag),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .mem_rsp_tag   (mem_rsp_tag),
        .mem_rsp_ready (mem_rsp_ready),
        .busy          (busy),
        .perf_reads    (perf_reads),
        .perf_writes   (perf_writes),
        .perf_latency  (perf_latency)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Called 1 ns after a rising edge, returns at the same point of the next cycle
    task automatic dcr_write(input logic [`GPU_DCR_ADDR_WIDTH-1:0] addr,
                             input logic [31:0] data);
        dcr_wr_valid = 1'b1;
        dcr_wr_addr  = addr;
        dcr_wr_data  = data;
        @(posedge clk);
        #1;
        dcr_wr_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (busy) begin
            if (cycles == IDLE_WAIT) begin
                $display("Timed out waiting for busy to fall at the end of a job");
                $display("Test failed");
                $fatal(1, "busy timeout");
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    // Memory: handshakes sampled mid-cycle, inputs driven 1 ns after the edge
    initial begin : memory_model
        logic                        req_fire;
        logic                        rsp_fire;
        logic                        fire_rw;
        logic [`GPU_ADDR_WIDTH-1:0]  fire_addr;
        logic [31:0]                 fire_data;
        logic [CB-1:0]               fire_tag;
        int                          first;
        int                          t;
        forever begin
            @(negedge clk);
            req_fire  = mem_req_valid && mem_req_ready;
            rsp_fire  = mem_rsp_valid && mem_rsp_ready;
            fire_rw   = mem_req_rw;
            fire_addr = mem_req_addr;
            fire_data = mem_req_data;
            fire_tag  = mem_req_tag;
            @(posedge clk);
            #1;
            if (rsp_fire) begin
                rsp_pending[mem_rsp_tag] = 1'b0;
                mem_rsp_valid = 1'b0;
            end
            for (int k = 0; k < N; k++) begin
                if (rsp_pending[k] && rsp_delay[k] > 0) begin
                    rsp_delay[k]--;
                end
            end
            if (req_fire) begin
                req_count++;
                if (fire_rw) begin
                    mem[fire_addr] = fire_data;
                end else if (rsp_pending[fire_tag]) begin
                    $display("Cluster %0d sent a second read before its first was answered",
                             fire_tag);
                    $display("Test failed");
                    $fatal(1, "read ordering broken");
                end else begin
                    rsp_pending[fire_tag] = 1'b1;
                    rsp_word[fire_tag]    = mem[fire_addr];
                    rsp_delay[fire_tag]   = 1 + int'($urandom % 5);
                end
            end
            // Random start tag lets responses overtake each other
            if (!mem_rsp_valid) begin
                first = int'($urandom % N);
                for (int k = 0; k < N; k++) begin
                    t = (first + k) % N;
                    if (!mem_rsp_valid && rsp_pending[t] && rsp_delay[t] == 0) begin
                        mem_rsp_valid = 1'b1;
                        mem_rsp_data  = rsp_word[t];
                        mem_rsp_tag   = t[CB-1:0];
                    end
                end
            end
            mem_req_ready = ($urandom % 4) != 0;
        end
    end

    initial begin : main
        int                          jobs;
        int                          reqs0;
        logic [31:0]                 src;
        logic [31:0]                 dst;
        logic [31:0]                 count;
        logic [31:0]                 addend;
        logic [31:0]                 exp_reads;
        logic [31:0]                 exp_writes;
        logic [`GPU_ADDR_WIDTH-1:0]  a16;
        perf_ctr_t                   reads0;
        perf_ctr_t                   writes0;
        perf_ctr_t                   lat0;
        void'($urandom(32'h9fff));
        reset         = 1'b1;
        dcr_wr_valid  = 1'b0;
        dcr_wr_addr   = '0;
        dcr_wr_data   = '0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        mem_rsp_tag   = '0;
        req_count     = 0;
        for (int k = 0; k < N; k++) begin
            rsp_pending[k] = 1'b0;
            rsp_word[k]    = '0;
            rsp_delay[k]   = 0;
        end
        for (int a = 0; a < 65536; a++) begin
            mem[a] = $urandom;
        end
        for (int i = 0; i < COLS*MAX_JOBS; i++) begin
            tests[i] = '1;
        end
        $readmemh("gpu_tests.txt", tests);
        jobs = 0;
        while (jobs < MAX_JOBS && tests[COLS*jobs] !== 32'hffff_ffff) begin
            jobs++;
        end
        if (jobs == 0) begin
            $display("No jobs could be read from gpu_tests.txt");
            $display("Test failed");
            $fatal(1, "empty job list");
        end

        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_value("busy", 32'(busy), 32'd0);
        check_value("mem_req_valid", 32'(mem_req_valid), 32'd0);
        check_value("perf_reads", perf_reads, 32'd0);
        check_value("perf_writes", perf_writes, 32'd0);
        check_value("perf_latency", perf_latency, 32'd0);
        @(posedge clk);
        #1;

        for (int j = 0; j < jobs; j++) begin
            src        = tests[COLS*j];
            dst        = tests[COLS*j+1];
            count      = tests[COLS*j+2];
            addend     = tests[COLS*j+3];
            exp_reads  = tests[COLS*j+4];
            exp_writes = tests[COLS*j+5];
            reads0     = perf_reads;
            writes0    = perf_writes;
            lat0       = perf_latency;
            reqs0      = req_count;

            // Reference image of memory after the job
            expect_mem = mem;
            for (int i = 0; i < int'(count); i++) begin
                a16 = dst[`GPU_ADDR_WIDTH-1:0] + `GPU_ADDR_WIDTH'(i);
                expect_mem[a16] = mem[src[`GPU_ADDR_WIDTH-1:0] + `GPU_ADDR_WIDTH'(i)] + addend;
            end

            dcr_write(DCR_SRC_BASE, src);
            dcr_write(DCR_DST_BASE, dst);
            dcr_write(DCR_WORD_COUNT, count);
            dcr_write(DCR_ADDEND, addend);
            dcr_write(DCR_START, 32'd1);
            @(negedge clk);
            check_value("busy one cycle after START", 32'(busy), 32'd0);
            @(negedge clk);
            check_value("busy before launch reaches top", 32'(busy), 32'd0);
            @(negedge clk);
            check_value("busy two cycles after START", 32'(busy), 32'd1);

            // A second START while running must be dropped
            if (count != 0) begin
                @(posedge clk);
                #1;
                dcr_write(DCR_START, 32'd1);
            end
            wait_idle();

            check_value("perf_reads delta", perf_reads - reads0, exp_reads);
            check_value("perf_writes delta", perf_writes - writes0, exp_writes);
            check_value("perf_reads vs word_count", perf_reads - reads0, count);
            check_value("perf_latency at least word_count",
                        32'(perf_latency - lat0 >= count), 32'd1);
            check_value("memory requests", 32'(req_count - reqs0), exp_reads + exp_writes);
            for (int a = 0; a < 65536; a++) begin
                check_value($sformatf("mem[%04h]", a), mem[a], expect_mem[a]);
            end
            @(posedge clk);
            #1;
        end

        $display("Test passed");
        $finish;
    end

endmodule

/* gpu_tests.txt */
// Columns (hex): src_base dst_base word_count addend exp_reads exp_writes
// Destination never overlaps the source of the same job
0100 0400 00000008 00000005 00000008 00000008
0200 0500 00000000 00001234 00000000 00000000
0300 0600 00000007 ffffffff 00000007 00000007
0010 0020 00000001 0000abcd 00000001 00000001
0800 0900 0000000d 80000000 0000000d 0000000d
0a00 0b00 00000002 00000001 00000002 00000002
0c00 2000 00000021 12345678 00000021 00000021
fff0 1000 00000020 00000003 00000020 00000020
0400 0700 00000009 00000011 00000009 00000009
3000 3100 00000000 0000ffff 00000000 00000000
3200 3300 00000003 00000000 00000003 00000003
4000 4100 00000040 7e5a0c31 00000040 00000040

/* sim.f */
+incdir+.
gpu_pkg.sv
elastic_buf.sv
mem_perf.sv
mem_arbiter.sv
cluster_engine.sv
dcr_ctrl.sv
gpu_top.sv
tb_gpu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_gpu -o tb_gpu

./obj_dir/tb_gpu > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
